//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_aes_wb
RTL_TOP  = aes_wb_top
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))
RTL_SRCS = $(filter src/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS) src/aes_defs.svh
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall +incdir+src --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/tb_aes_wb.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module tb_aes_wb;
    localparam int PERIOD           = 100;
    localparam int BLOCKS           = 40;
    localparam int CYCLES_PER_BLOCK = 40;
    localparam int WATCHDOG_NS      = BLOCKS * CYCLES_PER_BLOCK * PERIOD + 200000;

    logic            clk    = 1'b0;
    logic            arst_n = 1'b0;
    logic            cyc    = 1'b0;
    logic            stb    = 1'b0;
    logic            we     = 1'b0;
    wb_pkg::wb_adr_t adr    = '0;
    wb_pkg::wb_sel_t sel    = '0;
    wb_pkg::wb_dat_t dat_w  = '0;
    wb_pkg::wb_dat_t dat_r;
    logic            ack;

    int         errors = 0;
    int         checks = 0;
    time        ack_time;
    logic [7:0] sbox_tab [256];

    aes_wb_top dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .sel    (sel),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] times_two(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] x, input int s);
        logic [15:0] d;
        d = {x, x};
        return d[15 - s -: 8];
    endfunction

    // p steps through the powers of 3 while q steps through the powers of its inverse
    function automatic void build_sbox();
        logic [7:0] p;
        logic [7:0] q;
        logic [7:0] x;
        p = 8'h01;
        q = 8'h01;
        do begin
            p = p ^ times_two(p);
            q = q ^ {q[6:0], 1'b0};
            q = q ^ {q[5:0], 2'b00};
            q = q ^ {q[3:0], 4'h0};
            if (q[7]) begin
                q = q ^ 8'h09;
            end
            x = q ^ rotl8(q, 1) ^ rotl8(q, 2) ^ rotl8(q, 3) ^ rotl8(q, 4);
            sbox_tab[p] = x ^ 8'h63;
        end while (p != 8'h01);
        sbox_tab[0] = 8'h63;
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox_tab[w[31:24]], sbox_tab[w[23:16]], sbox_tab[w[15:8]], sbox_tab[w[7:0]]};
    endfunction

    function automatic logic [127:0] encrypt_ref(input logic [127:0] key, input logic [127:0] pt);
        logic [31:0]  w [44];
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [31:0]  tmp;
        logic [7:0]   rc;
        logic [7:0]   a0, a1, a2, a3;
        logic [127:0] ct;
        rc = 8'h01;
        for (int i = 0; i < 44; i++) begin
            if (i < 4) begin
                w[i] = key[127 - 32*i -: 32];
            end else begin
                tmp = w[i - 1];
                if (i % 4 == 0) begin
                    tmp = sub_word({tmp[23:0], tmp[31:24]}) ^ {rc, 24'h0};
                    rc = times_two(rc);
                end
                w[i] = w[i - 4] ^ tmp;
            end
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = pt[127 - 8*i -: 8] ^ w[i / 4][31 - 8*(i % 4) -: 8];
        end
        for (int r = 1; r <= `AES_ROUNDS; r++) begin
            // SubBytes, then row i%4 moves left by its row number
            for (int i = 0; i < 16; i++) begin
                t[i] = sbox_tab[s[(i % 4) + 4*(((i / 4) + (i % 4)) % 4)]];
            end
            for (int c = 0; c < 4; c++) begin
                a0 = t[4*c];
                a1 = t[4*c + 1];
                a2 = t[4*c + 2];
                a3 = t[4*c + 3];
                if (r < `AES_ROUNDS) begin
                    s[4*c]     = times_two(a0) ^ times_two(a1) ^ a1 ^ a2 ^ a3;
                    s[4*c + 1] = a0 ^ times_two(a1) ^ times_two(a2) ^ a2 ^ a3;
                    s[4*c + 2] = a0 ^ a1 ^ times_two(a2) ^ times_two(a3) ^ a3;
                    s[4*c + 3] = times_two(a0) ^ a0 ^ a1 ^ a2 ^ times_two(a3);
                end else begin
                    s[4*c]     = a0;
                    s[4*c + 1] = a1;
                    s[4*c + 2] = a2;
                    s[4*c + 3] = a3;
                end
                for (int k = 0; k < 4; k++) begin
                    s[4*c + k] = s[4*c + k] ^ w[4*r + c][31 - 8*k -: 8];
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            ct[127 - 8*i -: 8] = s[i];
        end
        return ct;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic bus_cycle(input logic [3:0] idx, input logic wr, input logic [31:0] d,
                             input logic [3:0] be, output logic [31:0] q);
        int n;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= {idx, 2'b00};
        sel   <= be;
        dat_w <= d;
        n = 0;
        @(negedge clk);
        while (!ack && n < 16) begin
            n++;
            @(negedge clk);
        end
        if (!ack) begin
            $display("bus cycle to register %0d got no ack at %0t", idx, $time);
            errors++;
        end
        q = dat_r;
        ack_time = $time;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] idx, input logic [31:0] d, input logic [3:0] be);
        logic [31:0] unused;
        bus_cycle(idx, 1'b1, d, be, unused);
    endtask

    task automatic wb_read(input logic [3:0] idx, output logic [31:0] q);
        bus_cycle(idx, 1'b0, 32'h0, 4'h0, q);
    endtask

    function automatic logic [3:0] reg_index(input int i);
        return (i < 4) ? 4'(`AES_REG_KEY0 + i) : 4'(`AES_REG_BLK0 + i - 4);
    endfunction

    task automatic load_block_regs(input logic [127:0] key, input logic [127:0] pt);
        for (int i = 0; i < 4; i++) begin
            wb_write(reg_index(i), key[127 - 32*i -: 32], 4'hf);
            wb_write(reg_index(i + 4), pt[127 - 32*i -: 32], 4'hf);
        end
    endtask

    task automatic read_result(output logic [127:0] res);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            wb_read(4'(`AES_REG_RES0 + i), w);
            res[127 - 32*i -: 32] = w;
        end
    endtask

    task automatic wait_done(input time t_start);
        logic [31:0] st;
        int          polls;
        polls = 0;
        st = '0;
        while (!st[1] && polls < 64) begin
            wb_read(`AES_REG_STAT, st);
            polls++;
        end
        if (!st[1]) begin
            $display("status never showed done, %0d polls from %0t", polls, t_start);
            errors++;
        end else begin
            check_value("status after done", 128'h2, st);
            if ($time - t_start < 21 * PERIOD) begin
                $display("done showed %0t ns after start, under 21 cycles", $time - t_start);
                errors++;
            end
        end
    endtask

    task automatic start_and_wait();
        logic [31:0] st;
        time         t0;
        wb_write(`AES_REG_CTRL, 32'h1, 4'h1);
        t0 = ack_time;
        // busy must be up and the old done flag cleared
        wb_read(`AES_REG_STAT, st);
        check_value("status after start", 128'h1, st);
        wait_done(t0);
    endtask

    task automatic encrypt_and_check(input logic [127:0] key, input logic [127:0] pt,
                                     input string name);
        logic [127:0] res;
        load_block_regs(key, pt);
        start_and_wait();
        read_result(res);
        check_value(name, encrypt_ref(key, pt), res);
    endtask

    task automatic check_readback();
        logic [31:0] shadow [8];
        logic [31:0] mask;
        logic [31:0] w;
        logic [3:0]  be;
        for (int i = 0; i < 8; i++) begin
            shadow[i] = $urandom();
            wb_write(reg_index(i), shadow[i], 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            wb_read(reg_index(i), w);
            check_value($sformatf("dat_r of register %0d", reg_index(i)), shadow[i], w);
        end
        // partial writes keep the bytes whose select is low
        for (int i = 0; i < 8; i++) begin
            be = 4'($urandom());
            w = $urandom();
            wb_write(reg_index(i), w, be);
            mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
            shadow[i] = (shadow[i] & ~mask) | (w & mask);
        end
        for (int i = 0; i < 8; i++) begin
            wb_read(reg_index(i), w);
            check_value($sformatf("dat_r of register %0d", reg_index(i)), shadow[i], w);
        end
    endtask

    function automatic logic [127:0] random_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t with the run still going", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [127:0] key;
        logic [127:0] pt;
        logic [127:0] res;
        logic [31:0]  st;
        time          t0;
        void'($urandom(32'h18067b04));
        build_sbox();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        wb_read(`AES_REG_STAT, st);
        check_value("status after reset", 128'h0, st);
        read_result(res);
        check_value("result after reset", 128'h0, res);

        check_readback();

        key = 128'h000102030405060708090a0b0c0d0e0f;
        pt  = 128'h00112233445566778899aabbccddeeff;
        check_value("model known answer", 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                    encrypt_ref(key, pt));
        load_block_regs(key, pt);
        start_and_wait();
        read_result(res);
        check_value("result known answer", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, res);

        for (int n = 0; n < 30; n++) begin
            encrypt_and_check(random_block(), random_block(), $sformatf("result block %0d", n));
        end

        // the second start lands while busy and the block change must not leak in
        key = random_block();
        pt  = random_block();
        load_block_regs(key, pt);
        wb_write(`AES_REG_CTRL, 32'h1, 4'h1);
        t0 = ack_time;
        wb_write(`AES_REG_BLK0, ~pt[127:96], 4'hf);
        wb_write(`AES_REG_CTRL, 32'h1, 4'h1);
        wait_done(t0);
        read_result(res);
        check_value("result after start while busy", encrypt_ref(key, pt), res);

        key = random_block();
        for (int n = 0; n < 4; n++) begin
            encrypt_and_check(key, random_block(), $sformatf("result same key %0d", n));
        end

        $display("%0d checks done, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

`define AES_ROUNDS 10
`define AES_NK 4

// word indices, the byte address is the index times four
`define AES_REG_KEY0 4'd0
`define AES_REG_BLK0 4'd4
`define AES_REG_CTRL 4'd8
`define AES_REG_STAT 4'd9
`define AES_REG_RES0 4'd12

`endif

//--- src/aes_key_sched.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_key_sched (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load,
    input  aes_pkg::key_t   key,
    input  logic            step,
    input  aes_pkg::round_t rcon_round,
    output aes_pkg::key_t   round_key
);
    aes_pkg::byte_t rcon;
    aes_pkg::word_t last;
    aes_pkg::word_t sub_w;
    aes_pkg::word_t chain;
    aes_pkg::key_t  next_key;

    always_comb begin
        case (rcon_round)
            4'd1:    rcon = 8'h01;
            4'd2:    rcon = 8'h02;
            4'd3:    rcon = 8'h04;
            4'd4:    rcon = 8'h08;
            4'd5:    rcon = 8'h10;
            4'd6:    rcon = 8'h20;
            4'd7:    rcon = 8'h40;
            4'd8:    rcon = 8'h80;
            4'd9:    rcon = 8'h1b;
            4'd10:   rcon = 8'h36;
            default: rcon = 8'h00;
        endcase
    end

    // RotWord then SubWord on the last word of the previous key
    assign last  = round_key[31:0];
    assign sub_w = {aes_pkg::sub_byte(last[23:16]) ^ rcon, aes_pkg::sub_byte(last[15:8]),
                    aes_pkg::sub_byte(last[7:0]), aes_pkg::sub_byte(last[31:24])};

    always_comb begin
        chain = sub_w;
        for (int i = 0; i < `AES_NK; i++) begin
            chain = chain ^ round_key[127 - 32*i -: 32];
            next_key[127 - 32*i -: 32] = chain;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            round_key <= '0;
        end else if (load) begin
            round_key <= key;
        end else if (step) begin
            round_key <= next_key;
        end
    end

endmodule

//--- src/aes_pkg.sv
package aes_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    // byte 0 of the state sits in bits 127:120
    typedef logic [127:0] block_t;
    typedef logic [127:0] key_t;
    typedef logic [3:0]   round_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        COMBINE,
        DONE
    } core_state_e;

    function automatic byte_t xtime(input byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t p;
        byte_t x;
        p = '0;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ x;
            end
            x = xtime(x);
        end
        return p;
    endfunction

    // a^254 is the inverse for nonzero a, and zero maps to zero
    function automatic byte_t gf_inv(input byte_t a);
        byte_t sq;
        byte_t r;
        sq = a;
        r = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq = gf_mul(sq, sq);
            r = gf_mul(r, sq);
        end
        return r;
    endfunction

    function automatic byte_t sub_byte(input byte_t a);
        byte_t b;
        b = gf_inv(a);
        // affine map, the inverse XORed with four left rotations of itself
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
               ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

endpackage

//--- src/aes_round_core.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_round_core (
    input  logic      clk,
    input  logic      arst_n,
    aes_round_if.core rif
);
    aes_pkg::core_state_e state;
    aes_pkg::round_t      round;
    aes_pkg::block_t      blk;
    aes_pkg::block_t      result;
    aes_pkg::block_t      next_blk;
    aes_pkg::key_t        round_key;
    aes_pkg::word_t       tw [4][4];
    logic                 accept;
    logic                 last_round;

    assign accept     = rif.start && (state == aes_pkg::IDLE || state == aes_pkg::DONE);
    assign last_round = (round == aes_pkg::round_t'(`AES_ROUNDS));

    aes_table_lookup col0 (.clk(clk), .column(blk[127:96]),
                           .t0(tw[0][0]), .t1(tw[0][1]), .t2(tw[0][2]), .t3(tw[0][3]));
    aes_table_lookup col1 (.clk(clk), .column(blk[95:64]),
                           .t0(tw[1][0]), .t1(tw[1][1]), .t2(tw[1][2]), .t3(tw[1][3]));
    aes_table_lookup col2 (.clk(clk), .column(blk[63:32]),
                           .t0(tw[2][0]), .t1(tw[2][1]), .t2(tw[2][2]), .t3(tw[2][3]));
    aes_table_lookup col3 (.clk(clk), .column(blk[31:0]),
                           .t0(tw[3][0]), .t1(tw[3][1]), .t2(tw[3][2]), .t3(tw[3][3]));

    // the next round key is ready by the time the COMBINE cycle needs it
    aes_key_sched key0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (accept),
        .key        (rif.key),
        .step       (state == aes_pkg::LOOKUP),
        .rcon_round (round),
        .round_key  (round_key)
    );

    // row r of output column j comes from input column j+r, which is ShiftRows
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            if (last_round) begin
                next_blk[127 - 32*j -: 32] = {tw[j][0][23:16], tw[(j + 1) % 4][1][15:8],
                                              tw[(j + 2) % 4][2][7:0],
                                              tw[(j + 3) % 4][3][31:24]}
                                             ^ round_key[127 - 32*j -: 32];
            end else begin
                next_blk[127 - 32*j -: 32] = tw[j][0] ^ tw[(j + 1) % 4][1]
                                             ^ tw[(j + 2) % 4][2] ^ tw[(j + 3) % 4][3]
                                             ^ round_key[127 - 32*j -: 32];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= aes_pkg::IDLE;
            round  <= '0;
            result <= '0;
        end else begin
            case (state)
                aes_pkg::IDLE, aes_pkg::DONE: begin
                    if (accept) begin
                        state <= aes_pkg::LOOKUP;
                        round <= aes_pkg::round_t'(1);
                    end else begin
                        state <= aes_pkg::IDLE;
                    end
                end
                aes_pkg::LOOKUP: state <= aes_pkg::COMBINE;
                aes_pkg::COMBINE: begin
                    if (last_round) begin
                        state  <= aes_pkg::DONE;
                        result <= next_blk;
                    end else begin
                        state <= aes_pkg::LOOKUP;
                        round <= aes_pkg::round_t'(round + 1'b1);
                    end
                end
                default: state <= aes_pkg::IDLE;
            endcase
        end
    end

    // the load cycle adds the cipher key to the plaintext
    always_ff @(posedge clk) begin
        if (accept) begin
            blk <= rif.block ^ rif.key;
        end else if (state == aes_pkg::COMBINE) begin
            blk <= next_blk;
        end
    end

    assign rif.busy   = (state == aes_pkg::LOOKUP) || (state == aes_pkg::COMBINE);
    assign rif.done   = (state == aes_pkg::DONE);
    assign rif.result = result;

    // the register block must hold back a start until the core is free
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        rif.start |-> !rif.busy);
    // done is a single cycle pulse one load cycle and two cycles per round after start
    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        rif.done |-> $past(rif.start, 2 * `AES_ROUNDS + 1) && !$past(rif.done));

endmodule

//--- src/aes_round_if.sv
`timescale 1ns/1ps

interface aes_round_if;
    logic            start;
    aes_pkg::key_t   key;
    aes_pkg::block_t block;
    logic            busy;
    logic            done;
    aes_pkg::block_t result;

    modport regs (
        output start,
        output key,
        output block,
        input  busy,
        input  done,
        input  result
    );

    modport core (
        input  start,
        input  key,
        input  block,
        output busy,
        output done,
        output result
    );
endinterface

//--- src/aes_table_lookup.sv
`timescale 1ns/1ps

module aes_table_lookup (
    input  logic           clk,
    input  aes_pkg::word_t column,
    output aes_pkg::word_t t0,
    output aes_pkg::word_t t1,
    output aes_pkg::word_t t2,
    output aes_pkg::word_t t3
);
    aes_pkg::byte_t s  [4];
    aes_pkg::byte_t s2 [4];
    aes_pkg::word_t tw [4];

    // one T word per row byte, laid out as S, S, 3S, 2S
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            s[i]  = aes_pkg::sub_byte(column[31 - 8*i -: 8]);
            s2[i] = aes_pkg::xtime(s[i]);
            tw[i] = {s[i], s[i], s2[i] ^ s[i], s2[i]};
        end
    end

    // the rotation puts each row's MixColumns coefficients in output column order
    always_ff @(posedge clk) begin
        t0 <= {tw[0][7:0], tw[0][31:8]};
        t1 <= {tw[1][15:0], tw[1][31:16]};
        t2 <= {tw[2][23:0], tw[2][31:24]};
        t3 <= tw[3];
    end

endmodule

//--- src/aes_wb_regs.sv
`timescale 1ns/1ps

module aes_wb_regs (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            cyc,
    input  logic            stb,
    input  logic            we,
    input  wb_pkg::wb_adr_t adr,
    input  wb_pkg::wb_sel_t sel,
    input  wb_pkg::wb_dat_t dat_w,
    output wb_pkg::wb_dat_t dat_r,
    output logic            ack,
    aes_round_if.regs       rif
);
    aes_pkg::key_t    key_q;
    aes_pkg::block_t  blk_q;
    wb_pkg::reg_idx_e idx;
    wb_pkg::wb_dat_t  rd_data;
    logic [1:0]       wsel;
    logic             req;
    logic             acked;
    logic             start_q;
    logic             done_q;

    function automatic wb_pkg::wb_dat_t merge_bytes(input wb_pkg::wb_dat_t old_w,
                                                    input wb_pkg::wb_dat_t new_w,
                                                    input wb_pkg::wb_sel_t be);
        wb_pkg::wb_dat_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    assign idx  = wb_pkg::reg_idx_e'(adr[5:2]);
    assign wsel = adr[3:2];
    // acked keeps a held strobe from being served twice
    assign req  = cyc && stb && !ack && !acked;

    always_comb begin
        case (idx)
            wb_pkg::REG_KEY0, wb_pkg::REG_KEY1,
            wb_pkg::REG_KEY2, wb_pkg::REG_KEY3:
                rd_data = key_q[32*(3 - int'(wsel)) +: 32];
            wb_pkg::REG_BLK0, wb_pkg::REG_BLK1,
            wb_pkg::REG_BLK2, wb_pkg::REG_BLK3:
                rd_data = blk_q[32*(3 - int'(wsel)) +: 32];
            wb_pkg::REG_RES0, wb_pkg::REG_RES1,
            wb_pkg::REG_RES2, wb_pkg::REG_RES3:
                rd_data = rif.result[32*(3 - int'(wsel)) +: 32];
            wb_pkg::REG_STAT: rd_data = {30'd0, done_q, rif.busy};
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            acked   <= 1'b0;
            dat_r   <= '0;
            key_q   <= '0;
            blk_q   <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            ack     <= req;
            acked   <= (acked || ack) && stb;
            start_q <= 1'b0;
            if (req) begin
                dat_r <= rd_data;
            end
            if (req && we) begin
                case (idx)
                    wb_pkg::REG_KEY0, wb_pkg::REG_KEY1,
                    wb_pkg::REG_KEY2, wb_pkg::REG_KEY3:
                        key_q[32*(3 - int'(wsel)) +: 32] <=
                            merge_bytes(key_q[32*(3 - int'(wsel)) +: 32], dat_w, sel);
                    wb_pkg::REG_BLK0, wb_pkg::REG_BLK1,
                    wb_pkg::REG_BLK2, wb_pkg::REG_BLK3:
                        blk_q[32*(3 - int'(wsel)) +: 32] <=
                            merge_bytes(blk_q[32*(3 - int'(wsel)) +: 32], dat_w, sel);
                    wb_pkg::REG_CTRL: start_q <= sel[0] && dat_w[0] && !rif.busy;
                    default: ;
                endcase
            end
            // a new start clears the done flag of the previous block
            if (start_q) begin
                done_q <= 1'b0;
            end else if (rif.done) begin
                done_q <= 1'b1;
            end
        end
    end

    assign rif.start = start_q;
    assign rif.key   = key_q;
    assign rif.block = blk_q;

    a_ack_stb: assert property (@(posedge clk) disable iff (!arst_n) ack |-> stb);

endmodule

//--- src/aes_wb_top.sv
`timescale 1ns/1ps

module aes_wb_top (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            cyc,
    input  logic            stb,
    input  logic            we,
    input  wb_pkg::wb_adr_t adr,
    input  wb_pkg::wb_sel_t sel,
    input  wb_pkg::wb_dat_t dat_w,
    output wb_pkg::wb_dat_t dat_r,
    output logic            ack
);
    aes_round_if rif ();

    aes_wb_regs regs0 (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .sel    (sel),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack),
        .rif    (rif.regs)
    );

    aes_round_core core0 (
        .clk    (clk),
        .arst_n (arst_n),
        .rif    (rif.core)
    );

endmodule

//--- src/wb_pkg.sv
`include "aes_defs.svh"

package wb_pkg;

    typedef logic [5:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    typedef logic [3:0]  wb_sel_t;

    // key, block and result are groups of four words, byte 0 in word 0
    typedef enum logic [3:0] {
        REG_KEY0 = `AES_REG_KEY0,
        REG_KEY1 = `AES_REG_KEY0 + 4'd1,
        REG_KEY2 = `AES_REG_KEY0 + 4'd2,
        REG_KEY3 = `AES_REG_KEY0 + 4'd3,
        REG_BLK0 = `AES_REG_BLK0,
        REG_BLK1 = `AES_REG_BLK0 + 4'd1,
        REG_BLK2 = `AES_REG_BLK0 + 4'd2,
        REG_BLK3 = `AES_REG_BLK0 + 4'd3,
        REG_CTRL = `AES_REG_CTRL,
        REG_STAT = `AES_REG_STAT,
        REG_RES0 = `AES_REG_RES0,
        REG_RES1 = `AES_REG_RES0 + 4'd1,
        REG_RES2 = `AES_REG_RES0 + 4'd2,
        REG_RES3 = `AES_REG_RES0 + 4'd3
    } reg_idx_e;

endpackage

//--- verilog.f
+incdir+src
src/aes_pkg.sv
src/wb_pkg.sv
src/aes_round_if.sv
src/aes_table_lookup.sv
src/aes_key_sched.sv
src/aes_round_core.sv
src/aes_wb_regs.sv
src/aes_wb_top.sv
dv/tb_aes_wb.sv
